/* src/boot_pkg.sv */
//##########################################################################
// shared types and constants for the secure boot sequencer
// secure memory is fixed at 16 words, so addresses are 4 bits wide
// chip ID and auth IDs are one 256-bit memory word each
// LC codes other than RAW, DEV, PROD and EOL are left unnamed
//##########################################################################
`default_nettype none

package boot_pkg;

    localparam int id_w   = 256;
    localparam int blk_w  = 512;
    localparam int gpio_w = 32;

    localparam logic [3:0] CHIP_ID_ADDR = 4'h0;
    localparam logic [3:0] LC_AUTH_BASE = 4'h8;    // plus lc state

    localparam logic [gpio_w-1:0] RST_REQ_WORD = 32'h1;
    localparam logic [gpio_w-1:0] RELEASE_WORD = 32'h10;

    localparam logic [5:0] GPIO_ODATA = 6'h0;
    localparam logic [5:0] GPIO_IDATA = 6'h5;

    typedef enum logic [2:0] {
        LC_RAW  = 3'd0,
        LC_DEV  = 3'd2,
        LC_PROD = 3'd3,
        LC_EOL  = 3'd5
    } lc_state_e;

    typedef enum logic [3:0] {
        BOOT_INIT, RESET_SOC, LC_AUTH_WAIT, LC_AUTH, CHALLENGE_GEN, CHALLENGE_READ,
        CHIPID_GEN, CHIPID_STORE, PROVISION_LC, LC_POLL, LC_TRANSITION, RESET_SOC2,
        OP_RELEASE, TRUNC_BOOT, ABORT
    } boot_state_e;

    typedef enum logic {
        HOST_RESET,
        HOST_RELEASE
    } host_op_e;

    typedef struct packed {
        logic [gpio_w-1:0] wdata;
        logic [5:0]        data_type;
        logic              rw;          // 1 = write
    } gpio_pkt_t;

    typedef struct packed {
        logic            rd_en;
        logic            wr_en;
        logic [3:0]      addr;
        logic [id_w-1:0] wdata;
    } mem_req_t;

endpackage

`default_nettype wire

/* src/host_link.sv */
//##########################################################################
// one host command at a time over the GPIO registers
// host acks reset on rdata bit 1, release on bit 5
// the ack bit must be held until the host sees the next write
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module host_link (
    input  logic                          clk,
    input  logic                          fuse,
    input  logic                          host_start,
    input  boot_pkg::host_op_e            host_op,
    input  logic [boot_pkg::gpio_w-1:0]   gpio_reg_rdata,
    output logic                          gpio_reg_access,
    output boot_pkg::gpio_pkt_t           gpio_reg_packet,
    output logic                          host_done
);
    import boot_pkg::*;

    typedef enum logic [1:0] {HL_IDLE, HL_CMD, HL_POLL} hl_phase_e;

    hl_phase_e phase;
    host_op_e  op_q;
    logic      ack;

    assign ack = (op_q == HOST_RELEASE) ? gpio_reg_rdata[5] : gpio_reg_rdata[1];

    always_ff @(posedge clk or negedge fuse) begin
        if (!fuse) begin
            phase     <= HL_IDLE;
            op_q      <= HOST_RESET;
            host_done <= 1'b0;
        end else begin
            host_done <= 1'b0;
            case (phase)
                HL_IDLE: begin
                    if (host_start) begin
                        op_q  <= host_op;
                        phase <= HL_CMD;
                    end
                end
                HL_CMD:  phase <= HL_POLL;  // write goes out for one cycle
                HL_POLL: begin
                    if (ack) begin
                        host_done <= 1'b1;
                        phase     <= HL_IDLE;
                    end
                end
                default: phase <= HL_IDLE;
            endcase
        end
    end

    always_comb begin
        gpio_reg_packet = '0;
        gpio_reg_access = (phase != HL_IDLE);
        gpio_reg_packet.wdata = (op_q == HOST_RELEASE) ? RELEASE_WORD : RST_REQ_WORD;
        if (phase == HL_CMD) begin
            gpio_reg_packet.rw        = 1'b1;
            gpio_reg_packet.data_type = GPIO_ODATA;
        end else begin
            gpio_reg_packet.data_type = GPIO_IDATA;   // poll for the ack
        end
    end

endmodule

`default_nettype wire

/* src/secure_mem_port.sv */
//##########################################################################
// single read or write to the 16-word secure memory
// reads hold rd_en and addr until rd_data_valid, write strobe is one cycle
// mem_width must be at least id_w, only the low id_w bits are kept
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module secure_mem_port #(
    parameter int mem_width = boot_pkg::id_w
) (
    input  logic                        clk,
    input  logic                        fuse,
    input  logic                        mem_rd_start,
    input  logic                        mem_wr_start,
    input  logic [3:0]                  mem_addr,
    input  logic [boot_pkg::id_w-1:0]   mem_wdata,
    input  logic [mem_width-1:0]        rd_data,
    input  logic                        rd_data_valid,
    output boot_pkg::mem_req_t          mem_req,
    output logic                        mem_done,
    output logic [boot_pkg::id_w-1:0]   rd_word
);
    import boot_pkg::*;

    always_ff @(posedge clk or negedge fuse) begin
        if (!fuse) begin
            mem_req  <= '0;
            mem_done <= 1'b0;
        end else begin
            mem_done <= 1'b0;
            if (mem_req.wr_en) begin
                mem_req.wr_en <= 1'b0;
                mem_done      <= 1'b1;
            end else if (mem_req.rd_en) begin
                if (rd_data_valid) begin
                    mem_req.rd_en <= 1'b0;
                    mem_done      <= 1'b1;
                end
            end else if (mem_rd_start || mem_wr_start) begin
                mem_req.rd_en <= mem_rd_start;
                mem_req.wr_en <= mem_wr_start && !mem_rd_start;   // read wins
                mem_req.addr  <= mem_addr;
                mem_req.wdata <= mem_wdata;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_req.rd_en && rd_data_valid) begin
            rd_word <= rd_data[id_w-1:0];
        end
    end

endmodule

`default_nettype wire

/* src/chip_id_engine.sv */
//##########################################################################
// chip ID = SHA digest of puf_a ^ puf_b, sent as one init block
// the upper half of the block is zero, no padding is added here
// digest is taken only once ready and valid are both high
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module chip_id_engine (
    input  logic                         clk,
    input  logic                         fuse,
    input  logic                         id_start,
    input  logic [boot_pkg::id_w-1:0]    puf_a,
    input  logic [boot_pkg::id_w-1:0]    puf_b,
    input  logic                         sha_ready,
    input  logic                         sha_digest_valid,
    input  logic [boot_pkg::id_w-1:0]    sha_digest,
    output logic [boot_pkg::blk_w-1:0]   sha_block,
    output logic                         sha_init,
    output logic                         id_done,
    output logic [boot_pkg::id_w-1:0]    chip_id
);
    import boot_pkg::*;

    logic busy;
    logic accept;
    logic capture;

    assign accept  = id_start && !busy;
    // skip the strobe cycle so a stale digest is not taken
    assign capture = busy && !sha_init && sha_ready && sha_digest_valid;

    always_ff @(posedge clk or negedge fuse) begin
        if (!fuse) begin
            busy     <= 1'b0;
            sha_init <= 1'b0;
            id_done  <= 1'b0;
        end else begin
            sha_init <= accept;
            id_done  <= capture;
            if (accept) begin
                busy <= 1'b1;
            end else if (capture) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            sha_block <= {{(blk_w - id_w){1'b0}}, puf_a ^ puf_b};
        end
        if (capture) begin
            chip_id <= sha_digest;
        end
    end

endmodule

`default_nettype wire

/* src/lc_port.sv */
//##########################################################################
// lifecycle controller request and completion
// lc_identifier is only non-zero during the request pulse
// lc_ok keeps the last lc_success until the next completion
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module lc_port (
    input  logic                        clk,
    input  logic                        fuse,
    input  logic                        lc_start,
    input  logic [boot_pkg::id_w-1:0]   lc_id,
    input  logic                        lc_done,
    input  logic                        lc_success,
    output logic                        lc_transition_request,
    output logic [boot_pkg::id_w-1:0]   lc_identifier,
    output logic                        lc_done_pulse,
    output logic                        lc_ok
);

    logic busy;
    logic accept;
    logic finish;

    assign accept = lc_start && !busy;
    assign finish = busy && !lc_transition_request && lc_done;

    always_ff @(posedge clk or negedge fuse) begin
        if (!fuse) begin
            busy                  <= 1'b0;
            lc_transition_request <= 1'b0;
            lc_identifier         <= '0;
            lc_done_pulse         <= 1'b0;
            lc_ok                 <= 1'b0;
        end else begin
            lc_transition_request <= accept;
            lc_identifier         <= accept ? lc_id : '0;
            lc_done_pulse         <= finish;
            if (finish) begin
                lc_ok <= lc_success;
                busy  <= 1'b0;
            end else if (accept) begin
                busy <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* src/boot_fsm.sv */
//##########################################################################
// boot sequence control, one engine active at a time
// starts are single-cycle pulses, one done pulse of any engine ends a step
// fuse is the only reset, every reset is treated as a first boot
// TRUNC_BOOT and ABORT are only left through fuse
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module boot_fsm (
    input  logic                         clk,
    input  logic                         fuse,
    input  boot_pkg::lc_state_e          lc_state,
    input  logic                         lc_req_in,
    input  logic [boot_pkg::id_w-1:0]    lc_req_id,
    input  logic                         lc_auth_valid,
    input  logic [boot_pkg::id_w-1:0]    lc_auth_id,
    input  logic                         host_done,
    input  logic                         mem_done,
    input  logic [boot_pkg::id_w-1:0]    rd_word,
    input  logic                         id_done,
    input  logic [boot_pkg::id_w-1:0]    chip_id,
    input  logic                         lc_done_pulse,
    input  logic                         lc_ok,
    output logic                         host_start,
    output boot_pkg::host_op_e           host_op,
    output logic                         mem_rd_start,
    output logic                         mem_wr_start,
    output logic [3:0]                   mem_addr,
    output logic [boot_pkg::id_w-1:0]    mem_wdata,
    output logic                         id_start,
    output logic                         lc_start,
    output logic [boot_pkg::id_w-1:0]    lc_id,
    output logic                         boot_fault,
    output logic                         trunc_boot
);
    import boot_pkg::*;

    boot_state_e     state, state_next;
    logic            pend, pend_next;   // engine started, done not seen yet
    logic            issue;
    logic            step_done;
    logic [id_w-1:0] id_q;              // auth or transition id from the host

    assign issue      = host_start | mem_rd_start | mem_wr_start | id_start | lc_start;
    assign step_done  = host_done | mem_done | id_done | lc_done_pulse;
    assign boot_fault = (state == ABORT);
    assign trunc_boot = (state == TRUNC_BOOT);

    always_comb begin
        host_start   = 1'b0;
        host_op      = HOST_RESET;
        mem_rd_start = 1'b0;
        mem_wr_start = 1'b0;
        mem_addr     = CHIP_ID_ADDR;
        mem_wdata    = chip_id;
        id_start     = 1'b0;
        lc_start     = 1'b0;
        lc_id        = id_q;
        case (state)
            BOOT_INIT:                 host_start = 1'b1;
            RESET_SOC2:                host_start = !pend;
            OP_RELEASE: begin
                host_start = !pend;
                host_op    = HOST_RELEASE;
            end
            CHIPID_GEN, CHALLENGE_GEN: id_start = !pend;
            CHIPID_STORE:              mem_wr_start = !pend;
            CHALLENGE_READ:            mem_rd_start = !pend;
            LC_AUTH: begin
                mem_rd_start = !pend;
                mem_addr     = LC_AUTH_BASE + {1'b0, lc_state};
            end
            PROVISION_LC: begin
                lc_start = !pend;
                lc_id    = '0;      // provisioning id
            end
            LC_TRANSITION:             lc_start = !pend;
            default: ;
        endcase
    end

    always_comb begin
        state_next = state;
        pend_next  = (pend | issue) & ~step_done;
        case (state)
            BOOT_INIT: state_next = RESET_SOC;
            RESET_SOC: begin
                if (step_done) begin
                    state_next = (lc_state == LC_RAW) ? CHIPID_GEN : LC_AUTH_WAIT;
                end
            end
            CHIPID_GEN:   if (step_done) state_next = CHIPID_STORE;
            CHIPID_STORE: if (step_done) state_next = PROVISION_LC;
            PROVISION_LC: if (step_done) state_next = LC_POLL;   // result not checked
            LC_AUTH_WAIT: if (lc_auth_valid) state_next = LC_AUTH;
            LC_AUTH: begin
                if (step_done) begin
                    if (rd_word != id_q) begin
                        state_next = LC_AUTH_WAIT;
                    end else if (lc_state == LC_EOL) begin
                        state_next = TRUNC_BOOT;
                    end else begin
                        state_next = CHALLENGE_GEN;
                    end
                end
            end
            CHALLENGE_GEN: if (step_done) state_next = CHALLENGE_READ;
            CHALLENGE_READ: begin
                if (step_done) begin
                    if (rd_word != chip_id) begin
                        state_next = ABORT;
                    end else if (lc_state == LC_PROD) begin
                        state_next = OP_RELEASE;
                    end else begin
                        state_next = LC_POLL;
                    end
                end
            end
            OP_RELEASE:    if (step_done) state_next = LC_POLL;
            LC_POLL:       if (lc_req_in) state_next = LC_TRANSITION;
            LC_TRANSITION: if (step_done) state_next = lc_ok ? RESET_SOC2 : LC_POLL;
            RESET_SOC2:    if (step_done) state_next = BOOT_INIT;
            TRUNC_BOOT, ABORT: ;
            default:       state_next = ABORT;
        endcase
    end

    always_ff @(posedge clk or negedge fuse) begin
        if (!fuse) begin
            state <= BOOT_INIT;
            pend  <= 1'b0;
        end else begin
            state <= state_next;
            pend  <= pend_next;
        end
    end

    always_ff @(posedge clk) begin
        if (state == LC_POLL && lc_req_in) begin
            id_q <= lc_req_id;
        end else if (state == LC_AUTH_WAIT && lc_auth_valid) begin
            id_q <= lc_auth_id;
        end
    end

endmodule

`default_nettype wire

/* src/secure_boot_top.sv */
//##########################################################################
// secure boot sequencer top level
// fuse is the only reset, asynchronous and active low
// SHA core, secure memory, LC controller and host are outside this block
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module secure_boot_top #(
    parameter int mem_width = boot_pkg::id_w
) (
    input  logic                          clk,
    input  logic                          fuse,
    input  logic [boot_pkg::gpio_w-1:0]   gpio_reg_rdata,
    output logic                          gpio_reg_access,
    output boot_pkg::gpio_pkt_t           gpio_reg_packet,
    output logic [boot_pkg::blk_w-1:0]    sha_block,
    output logic                          sha_init,
    input  logic                          sha_ready,
    input  logic                          sha_digest_valid,
    input  logic [boot_pkg::id_w-1:0]     sha_digest,
    output boot_pkg::mem_req_t            mem_req,
    input  logic [mem_width-1:0]          rd_data,
    input  logic                          rd_data_valid,
    input  boot_pkg::lc_state_e           lc_state,
    output logic                          lc_transition_request,
    output logic [boot_pkg::id_w-1:0]     lc_identifier,
    input  logic                          lc_done,
    input  logic                          lc_success,
    input  logic                          lc_req_in,
    input  logic [boot_pkg::id_w-1:0]     lc_req_id,
    input  logic                          lc_auth_valid,
    input  logic [boot_pkg::id_w-1:0]     lc_auth_id,
    input  logic [boot_pkg::id_w-1:0]     puf_a,
    input  logic [boot_pkg::id_w-1:0]     puf_b,
    output logic                          boot_fault,
    output logic                          trunc_boot
);
    import boot_pkg::*;

    logic            host_start;
    host_op_e        host_op;
    logic            host_done;
    logic            mem_rd_start;
    logic            mem_wr_start;
    logic [3:0]      mem_addr;
    logic [id_w-1:0] mem_wdata;
    logic            mem_done;
    logic [id_w-1:0] rd_word;
    logic            id_start;
    logic            id_done;
    logic [id_w-1:0] chip_id;
    logic            lc_start;
    logic [id_w-1:0] lc_id;
    logic            lc_done_pulse;
    logic            lc_ok;

    boot_fsm u_fsm (.*);

    host_link u_host (.*);

    secure_mem_port #(
        .mem_width (mem_width)
    ) u_mem (.*);

    chip_id_engine u_chip_id (.*);

    lc_port u_lc (.*);

endmodule

`default_nettype wire

/* dv/tb_secure_boot.sv */
//##########################################################################
// directed testbench for the secure boot sequencer
// host, memory, SHA and LC responders are behavioral, delays of 0 to 3 cycles
// all stimulus and all response sampling happen on the falling clock edge
// the run stops at the first mismatch or after 1200 cycles
//##########################################################################
`timescale 1ns/1ps
`default_nettype none

module tb_secure_boot;
    import boot_pkg::*;

    localparam logic [id_w-1:0] SHA_K = {8{32'h5a17_c3e9}};  // model digest mask
    localparam int max_cycles = 6 * 200;

    logic clk = 1'b0;
    logic fuse;
    logic [gpio_w-1:0] gpio_reg_rdata;
    logic gpio_reg_access;
    gpio_pkt_t gpio_reg_packet;
    logic [blk_w-1:0] sha_block;
    logic sha_init, sha_ready, sha_digest_valid;
    logic [id_w-1:0] sha_digest;
    mem_req_t mem_req;
    logic [id_w-1:0] rd_data;
    logic rd_data_valid;
    lc_state_e lc_state;
    logic lc_transition_request;
    logic [id_w-1:0] lc_identifier;
    logic lc_done, lc_success, lc_req_in, lc_auth_valid;
    logic [id_w-1:0] lc_req_id, lc_auth_id, puf_a, puf_b;
    logic boot_fault, trunc_boot;

    logic [id_w-1:0] mem [16];
    logic [gpio_w-1:0] host_q [$];
    logic [3:0] rd_q [$];
    logic [3:0] wr_addr_q [$];
    logic [id_w-1:0] wr_data_q [$];
    logic [id_w-1:0] lc_q [$];
    int host_wait, host_bit, rd_wait, sha_wait, lc_wait;
    logic host_pend, sha_pend, lc_pend, lc_result;
    int sha_count, acc_cycles, cycles;

    secure_boot_top #(.mem_width(id_w)) i_dut (.*);

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles > max_cycles) begin
            $display("run did not finish within %0d cycles", max_cycles);
            $display("** FAIL **");
            $fatal(1);
        end
    end

    // responders
    always @(negedge clk) begin
        if (!fuse) begin
            gpio_reg_rdata   = '0;
            host_pend        = 1'b0;
            rd_data_valid    = 1'b0;
            rd_wait          = 0;
            sha_digest_valid = 1'b0;
            sha_pend         = 1'b0;
            lc_done          = 1'b0;
            lc_pend          = 1'b0;
        end else begin
            if (gpio_reg_access) begin
                acc_cycles++;
                check_value("gpio_reg_packet.data_type", id_w'(gpio_reg_packet.data_type),
                            gpio_reg_packet.rw ? id_w'(GPIO_ODATA) : id_w'(GPIO_IDATA));
            end
            if (gpio_reg_access && gpio_reg_packet.rw) begin
                host_q.push_back(gpio_reg_packet.wdata);
                gpio_reg_rdata = '0;
                host_bit  = (gpio_reg_packet.wdata == RELEASE_WORD) ? 5 : 1;
                host_wait = $urandom % 4;
                host_pend = 1'b1;
            end else if (host_pend) begin
                if (host_wait == 0) begin
                    gpio_reg_rdata[host_bit] = 1'b1;
                    host_pend = 1'b0;
                end else host_wait--;
            end
            if (mem_req.wr_en) begin
                mem[mem_req.addr] = mem_req.wdata;
                wr_addr_q.push_back(mem_req.addr);
                wr_data_q.push_back(mem_req.wdata);
            end
            if (rd_data_valid) begin
                rd_data_valid = 1'b0;
                rd_wait = $urandom % 4;
            end else if (mem_req.rd_en) begin
                if (rd_wait == 0) begin
                    rd_data = mem[mem_req.addr];
                    rd_data_valid = 1'b1;
                    rd_q.push_back(mem_req.addr);
                end else rd_wait--;
            end
            if (sha_init) begin
                check_value("sha_block", sha_block[blk_w-1:id_w], '0);  // upper half
                sha_count++;
                sha_digest_valid = 1'b0;
                sha_wait = $urandom % 4;
                sha_pend = 1'b1;
            end else if (sha_pend) begin
                if (sha_wait == 0) begin
                    sha_digest = sha_block[id_w-1:0] ^ SHA_K;
                    sha_digest_valid = 1'b1;
                    sha_pend = 1'b0;
                end else sha_wait--;
            end
            lc_done = 1'b0;
            if (!lc_transition_request) begin
                check_value("lc_identifier", lc_identifier, '0);
            end
            if (lc_transition_request) begin
                lc_q.push_back(lc_identifier);
                lc_wait = $urandom % 4;
                lc_pend = 1'b1;
            end else if (lc_pend) begin
                if (lc_wait == 0) begin
                    lc_done = 1'b1;
                    lc_success = lc_result;
                    lc_pend = 1'b0;
                end else lc_wait--;
            end
        end
    end

    task automatic check_value(input string name, input logic [id_w-1:0] got,
                               input logic [id_w-1:0] exp);
        assert (got === exp) else begin
            $display("[FAIL] %s got %h expected %h", name, got, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("check failed: %s", what);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    function automatic logic [id_w-1:0] rand_word();
        logic [id_w-1:0] w;
        for (int i = 0; i < 8; i++) w[i*32 +: 32] = $urandom;
        return w;
    endfunction

    function automatic int reads_of(input logic [3:0] addr);
        int n;
        n = 0;
        foreach (rd_q[i]) if (rd_q[i] == addr) n++;
        return n;
    endfunction

    task automatic apply_reset(input lc_state_e st);
        @(negedge clk);
        fuse = 1'b0;
        lc_state = st;
        lc_req_in = 1'b0;
        lc_auth_valid = 1'b0;
        lc_result = 1'b0;
        puf_a = rand_word();
        puf_b = rand_word();
        host_q.delete();
        rd_q.delete();
        wr_addr_q.delete();
        wr_data_q.delete();
        lc_q.delete();
        sha_count = 0;
        acc_cycles = 0;
        repeat (2) @(negedge clk);
        fuse = 1'b1;
    endtask

    task automatic first_boot();
        apply_reset(LC_RAW);
        while (host_q.size() < 1) @(negedge clk);
        check_value("gpio_reg_packet.wdata", id_w'(host_q[0]), id_w'(RST_REQ_WORD));
        while (lc_q.size() < 1) @(negedge clk);
        check_true(wr_addr_q.size() == 1, "exactly one memory write before provisioning");
        check_value("mem_req.addr", id_w'(wr_addr_q[0]), id_w'(CHIP_ID_ADDR));
        check_value("mem_req.wdata", wr_data_q[0], puf_a ^ puf_b ^ SHA_K);
        check_value("lc_identifier", lc_q[0], '0);
    endtask

    task automatic poll_transition();
        logic [id_w-1:0] id;
        first_boot();
        id = rand_word();
        lc_req_id = id;
        lc_req_in = 1'b1;
        while (lc_q.size() < 2) @(negedge clk);
        lc_req_in = 1'b0;
        check_value("lc_identifier", lc_q[1], id);
        repeat (20) @(negedge clk);
        check_true(host_q.size() == 1, "host command after a failed transition");
        lc_result = 1'b1;
        id = rand_word();
        lc_req_id = id;
        lc_req_in = 1'b1;
        while (lc_q.size() < 3) @(negedge clk);
        lc_req_in = 1'b0;
        check_value("lc_identifier", lc_q[2], id);
        while (host_q.size() < 3) @(negedge clk);
        check_value("gpio_reg_packet.wdata", id_w'(host_q[1]), id_w'(RST_REQ_WORD));
        check_value("gpio_reg_packet.wdata", id_w'(host_q[2]), id_w'(RST_REQ_WORD));
    endtask

    task automatic auth_mismatch_match();
        logic [id_w-1:0] auth;
        auth = rand_word();
        apply_reset(LC_DEV);
        mem[10] = auth;
        mem[0] = puf_a ^ puf_b ^ SHA_K;
        lc_auth_id = auth ^ 256'h1;
        lc_auth_valid = 1'b1;
        while (rd_q.size() < 1) @(negedge clk);
        lc_auth_valid = 1'b0;
        check_value("mem_req.addr", id_w'(rd_q[0]), id_w'(4'd10));
        repeat (10) @(negedge clk);
        check_true(reads_of(4'd0) == 0, "word 0 read after an auth mismatch");
        lc_auth_id = auth;
        lc_auth_valid = 1'b1;
        while (reads_of(4'd0) < 1) @(negedge clk);
        lc_auth_valid = 1'b0;
        check_true(reads_of(4'd10) == 2, "word 0 read without a second auth read");
    endtask

    task automatic prod_release();
        logic [id_w-1:0] auth;
        auth = rand_word();
        apply_reset(LC_PROD);
        mem[11] = auth;
        mem[0] = puf_a ^ puf_b ^ SHA_K;
        lc_auth_id = auth;
        lc_auth_valid = 1'b1;
        while (host_q.size() < 2) @(negedge clk);
        lc_auth_valid = 1'b0;
        check_value("gpio_reg_packet.wdata", id_w'(host_q[1]), id_w'(RELEASE_WORD));
    endtask

    task automatic challenge_fail();
        logic [id_w-1:0] auth;
        int acc;
        auth = rand_word();
        apply_reset(LC_DEV);
        mem[10] = auth;
        mem[0] = puf_a ^ puf_b ^ SHA_K ^ 256'h100;
        lc_auth_id = auth;
        lc_auth_valid = 1'b1;
        while (!boot_fault) @(negedge clk);
        lc_auth_valid = 1'b0;
        acc = acc_cycles;
        repeat (10) @(negedge clk);
        check_true(acc_cycles == acc, "GPIO access after abort");
        check_value("boot_fault", id_w'(boot_fault), id_w'(1'b1));
    endtask

    task automatic end_of_life();
        logic [id_w-1:0] auth;
        auth = rand_word();
        apply_reset(LC_EOL);
        mem[13] = auth;
        lc_auth_id = auth;
        lc_auth_valid = 1'b1;
        while (!trunc_boot) @(negedge clk);
        lc_auth_valid = 1'b0;
        repeat (5) @(negedge clk);
        check_true(reads_of(4'd0) == 0, "word 0 read in end of life");
        check_true(sha_count == 0, "SHA core started in end of life");
    endtask

    initial begin
        void'($urandom(41));
        fuse = 1'b0;
        gpio_reg_rdata = '0;
        sha_ready = 1'b1;
        sha_digest_valid = 1'b0;
        sha_digest = '0;
        rd_data = '0;
        rd_data_valid = 1'b0;
        lc_state = LC_RAW;
        lc_done = 1'b0;
        lc_success = 1'b0;
        lc_req_in = 1'b0;
        lc_req_id = '0;
        lc_auth_valid = 1'b0;
        lc_auth_id = '0;
        puf_a = '0;
        puf_b = '0;
        cycles = 0;
        for (int a = 0; a < 16; a++) mem[a] = {8{32'(a) * 32'h0101_0101 ^ 32'ha5a5_0000}};
        first_boot();
        poll_transition();
        auth_mismatch_match();
        prod_release();
        challenge_fail();
        end_of_life();
        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
src/boot_pkg.sv
src/host_link.sv
src/secure_mem_port.sv
src/chip_id_engine.sv
src/lc_port.sv
src/boot_fsm.sv
src/secure_boot_top.sv
dv/tb_secure_boot.sv

/* run.sh */
#!/bin/sh
# build and run the secure boot testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f filelist.f --top-module tb_secure_boot -o sim_tb \
    && ./obj_dir/sim_tb > sim.log 2>&1
cat sim.log
grep -q "\*\* PASS \*\*" sim.log && exit 0 || exit 1
